/* hw/ttc_params.svh */
`ifndef TTC_PARAMS_SVH
`define TTC_PARAMS_SVH

// ----------------------------------------
// counter, interval and match width
// ----------------------------------------
`define TTC_CNT_W 16

// ----------------------------------------
// register map, byte addresses on paddr
// ----------------------------------------
`define TTC_ADDR_CLK_CTRL  8'h00
`define TTC_ADDR_CNTR_CTRL 8'h04
`define TTC_ADDR_CNT_VAL   8'h08
`define TTC_ADDR_INTERVAL  8'h0C
`define TTC_ADDR_MATCH     8'h10
`define TTC_ADDR_INT_STS   8'h14

// clock control fields
`define TTC_CLK_PS_EN  0
`define TTC_CLK_PS_LSB 1
`define TTC_CLK_PS_MSB 4

// counter control bits
`define TTC_CTRL_DIS     0
`define TTC_CTRL_INTV    1
`define TTC_CTRL_MATCH   3
`define TTC_CTRL_RESTART 4

`endif

/* hw/ttc_pkg.sv */
`default_nettype none

`include "ttc_params.svh"

package ttc_pkg;

  // ----------------------------------------
  // data types
  // ----------------------------------------

  // counter value, also interval and match
  typedef logic [`TTC_CNT_W-1:0] cnt_t;

  // clock control register
  // bit 0 prescale enable, bits 4..1 prescale value
  // bits 5 and 6 kept for readback only
  typedef logic [6:0] clk_ctrl_t;

  // interrupt status, one bit per source
  typedef logic [2:0] int_sts_t;

  // ----------------------------------------
  // interrupt status bit positions
  // ----------------------------------------
  localparam int INT_OVF   = 0;
  localparam int INT_INTV  = 1;
  localparam int INT_MATCH = 2;

endpackage

`default_nettype wire

/* hw/ttc_apb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ttc_params.svh"

module ttc_apb_regs (
  input  logic               pclk28,
  input  logic               n_p_reset28,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [7:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               clk_ctrl_sel,
  output logic               restart,
  output logic               dis,
  output logic               intv_mode,
  output logic               match_en,
  output ttc_pkg::cnt_t      interval,
  output ttc_pkg::cnt_t      match,
  input  ttc_pkg::clk_ctrl_t clk_ctrl,
  input  ttc_pkg::cnt_t      cnt_val,
  input  logic               ovf_ev,
  input  logic               intv_ev,
  input  logic               match_ev,
  output logic               irq
);
  import ttc_pkg::*;

  // access phase qualifiers
  logic                          wr_en;
  logic                          rd_en;
  // counter control, restart bit not kept
  logic [`TTC_CTRL_RESTART-1:0]  cntr_ctrl;
  int_sts_t                      int_sts;
  int_sts_t                      int_ev;

  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & penable & ~pwrite;

  // clock control itself lives in ttc_count_rst
  assign clk_ctrl_sel = wr_en & (paddr == `TTC_ADDR_CLK_CTRL);

  // ----------------------------------------
  // write side
  // ----------------------------------------
  always_ff @(posedge pclk28 or negedge n_p_reset28)
  begin
    if (!n_p_reset28)
    begin
      cntr_ctrl <= '0;
      restart   <= 1'b0;
      interval  <= '0;
      match     <= '0;
    end
    else
    begin
      // one cycle strobe, bit 4 is write only
      restart <= wr_en & (paddr == `TTC_ADDR_CNTR_CTRL) & pwdata[`TTC_CTRL_RESTART];
      if (wr_en && (paddr == `TTC_ADDR_CNTR_CTRL))
        cntr_ctrl <= pwdata[`TTC_CTRL_RESTART-1:0];
      if (wr_en && (paddr == `TTC_ADDR_INTERVAL))
        interval <= pwdata[`TTC_CNT_W-1:0];
      if (wr_en && (paddr == `TTC_ADDR_MATCH))
        match <= pwdata[`TTC_CNT_W-1:0];
    end
  end

  // control levels to the counter
  // bit 2 is stored and read back, no function here
  assign dis       = cntr_ctrl[`TTC_CTRL_DIS];
  assign intv_mode = cntr_ctrl[`TTC_CTRL_INTV];
  assign match_en  = cntr_ctrl[`TTC_CTRL_MATCH];

  // ----------------------------------------
  // interrupt status, clear on read
  // ----------------------------------------
  assign int_ev[INT_OVF]   = ovf_ev;
  assign int_ev[INT_INTV]  = intv_ev;
  assign int_ev[INT_MATCH] = match_ev;

  always_ff @(posedge pclk28 or negedge n_p_reset28)
  begin
    if (!n_p_reset28)
      int_sts <= '0;
    else if (rd_en && (paddr == `TTC_ADDR_INT_STS))
      // new event in the read cycle survives the clear
      int_sts <= int_ev;
    else
      int_sts <= int_sts | int_ev;
  end

  assign irq = |int_sts;

  // read mux, unused upper bits read as zero
  always_comb
  begin
    prdata = '0;
    case (paddr)
      `TTC_ADDR_CLK_CTRL:  prdata[$bits(clk_ctrl_t)-1:0] = clk_ctrl;
      `TTC_ADDR_CNTR_CTRL: prdata[`TTC_CTRL_RESTART-1:0] = cntr_ctrl;
      `TTC_ADDR_CNT_VAL:   prdata[`TTC_CNT_W-1:0] = cnt_val;
      `TTC_ADDR_INTERVAL:  prdata[`TTC_CNT_W-1:0] = interval;
      `TTC_ADDR_MATCH:     prdata[`TTC_CNT_W-1:0] = match;
      `TTC_ADDR_INT_STS:   prdata[$bits(int_sts_t)-1:0] = int_sts;
      default:             prdata = '0;
    endcase
  end

  // master protocol, access phase only inside a selected transfer
  a_penable_needs_psel: assert property (
    @(posedge pclk28) disable iff (!n_p_reset28)
    penable |-> psel
  ) else $error("penable high without psel");

endmodule

`default_nettype wire

/* hw/ttc_count_rst.sv */
`timescale 1ns/100ps
`default_nettype none

module ttc_count_rst (
  input  logic               pclk28,
  input  logic               n_p_reset28,
  input  logic [6:0]         pwdata,
  input  logic               clk_ctrl_sel,
  input  logic               restart,
  output logic               count_en,
  output ttc_pkg::clk_ctrl_t clk_ctrl
);

  // restart seen last cycle
  logic restart_q;

  // ----------------------------------------
  // counter enable with restart gap
  // ----------------------------------------
  // a rising restart drops count_en for one cycle
  // a held restart does not drop it again
  always_ff @(posedge pclk28 or negedge n_p_reset28)
  begin
    if (!n_p_reset28)
    begin
      restart_q <= 1'b0;
      count_en  <= 1'b0;
    end
    else
    begin
      restart_q <= restart;
      count_en  <= ~(restart & ~restart_q);
    end
  end

  // ----------------------------------------
  // clock control register
  // ----------------------------------------
  always_ff @(posedge pclk28 or negedge n_p_reset28)
  begin
    if (!n_p_reset28)
      clk_ctrl <= '0;
    else if (clk_ctrl_sel)
      clk_ctrl <= pwdata;
  end

  // gap is one cycle wide, never longer
  a_count_en_gap: assert property (
    @(posedge pclk28) disable iff (!n_p_reset28)
    !count_en |=> count_en
  ) else $error("count_en low for more than one cycle");

endmodule

`default_nettype wire

/* hw/ttc_prescaler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ttc_params.svh"

module ttc_prescaler (
  input  logic               pclk28,
  input  logic               n_p_reset28,
  input  logic               count_en,
  input  ttc_pkg::clk_ctrl_t clk_ctrl,
  output logic               tick
);

  // prescale field width and divider length
  localparam int PS_W  = `TTC_CLK_PS_MSB - `TTC_CLK_PS_LSB + 1;
  localparam int DIV_W = 2 ** PS_W;

  logic             ps_en;
  logic [PS_W-1:0]  ps_val;
  logic [DIV_W-1:0] div_cnt;
  logic [DIV_W-1:0] div_mask;
  logic             div_hit;

  assign ps_en  = clk_ctrl[`TTC_CLK_PS_EN];
  assign ps_val = clk_ctrl[`TTC_CLK_PS_MSB:`TTC_CLK_PS_LSB];

  // ----------------------------------------
  // divide by 2^(N+1)
  // ----------------------------------------
  // low N+1 bits of the divider are watched
  always_comb
  begin
    for (int i = 0; i < DIV_W; i++)
    begin
      div_mask[i] = (i <= int'(ps_val));
    end
  end

  // free running, held at zero while idle or bypassed
  always_ff @(posedge pclk28 or negedge n_p_reset28)
  begin
    if (!n_p_reset28)
      div_cnt <= '0;
    else if (!count_en || !ps_en)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + DIV_W'(1);
  end

  // all watched bits set, once per period
  assign div_hit = &(div_cnt | ~div_mask);

  // bypass gives a tick on every enabled cycle
  assign tick = count_en & (~ps_en | div_hit);

  // shortest prescaled period is two cycles
  a_tick_spacing: assert property (
    @(posedge pclk28) disable iff (!n_p_reset28)
    (tick && ps_en) |=> !(tick && ps_en)
  ) else $error("prescaled tick high two cycles in a row");

endmodule

`default_nettype wire

/* hw/ttc_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module ttc_counter (
  input  logic          pclk28,
  input  logic          n_p_reset28,
  input  logic          count_en,
  input  logic          tick,
  input  logic          dis,
  input  logic          intv_mode,
  input  logic          match_en,
  input  ttc_pkg::cnt_t interval,
  input  ttc_pkg::cnt_t match,
  output ttc_pkg::cnt_t cnt_val,
  output logic          ovf_ev,
  output logic          intv_ev,
  output logic          match_ev
);
  import ttc_pkg::*;

  // advance qualifier
  logic adv;
  // compare results
  logic at_intv;
  logic at_top;
  logic at_match;
  // value after this tick
  cnt_t cnt_nxt;

  // ----------------------------------------
  // advance and compare
  // ----------------------------------------

  // count only on an enabled tick
  // dis freezes the value but keeps it
  assign adv = count_en & tick & ~dis;

  // interval reached
  assign at_intv = (cnt_val == interval);

  // all ones, next step overflows
  assign at_top = &cnt_val;

  // match value reached
  assign at_match = (cnt_val == match);

  // wrap point depends on mode
  always_comb
  begin
    if (intv_mode && at_intv)
      cnt_nxt = '0;
    else
      // overflow mode wraps by itself
      cnt_nxt = cnt_val + cnt_t'(1);
  end

  // ----------------------------------------
  // counter register
  // ----------------------------------------
  // count_en low clears, restart gap lands here
  always_ff @(posedge pclk28 or negedge n_p_reset28)
  begin
    if (!n_p_reset28)
      cnt_val <= '0;
    else if (!count_en)
      cnt_val <= '0;
    else if (adv)
      cnt_val <= cnt_nxt;
  end

  // ----------------------------------------
  // event pulses
  // ----------------------------------------
  // all are single cycle, only on an advancing tick

  // interval wrap in interval mode
  assign intv_ev = adv & intv_mode & at_intv;

  // all ones wrap in overflow mode
  assign ovf_ev = adv & ~intv_mode & at_top;

  // compare hit, gated by enable
  assign match_ev = adv & match_en & at_match;

  // a wrap event always lands the value on zero
  a_wrap_to_zero: assert property (
    @(posedge pclk28) disable iff (!n_p_reset28)
    (intv_ev || ovf_ev) |=> (cnt_val == '0)
  ) else $error("counter not zero after a wrap event");

endmodule

`default_nettype wire

/* hw/ttc_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module ttc_timer (
  input  logic        pclk28,
  input  logic        n_p_reset28,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        irq
);
  import ttc_pkg::*;

  // register file to count reset block
  logic      clk_ctrl_sel;
  logic      restart;
  // control levels
  logic      dis;
  logic      intv_mode;
  logic      match_en;
  cnt_t      interval;
  cnt_t      match;
  // clock control and enable
  clk_ctrl_t clk_ctrl;
  logic      count_en;
  logic      tick;
  // counter back to the register file
  cnt_t      cnt_val;
  logic      ovf_ev;
  logic      intv_ev;
  logic      match_ev;

  // ----------------------------------------
  // APB registers and status
  // ----------------------------------------
  ttc_apb_regs u_apb_regs (
    .pclk28       (pclk28),
    .n_p_reset28  (n_p_reset28),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .clk_ctrl_sel (clk_ctrl_sel),
    .restart      (restart),
    .dis          (dis),
    .intv_mode    (intv_mode),
    .match_en     (match_en),
    .interval     (interval),
    .match        (match),
    .clk_ctrl     (clk_ctrl),
    .cnt_val      (cnt_val),
    .ovf_ev       (ovf_ev),
    .intv_ev      (intv_ev),
    .match_ev     (match_ev),
    .irq          (irq)
  );

  // clock control register and restart gap
  ttc_count_rst u_count_rst (
    .pclk28       (pclk28),
    .n_p_reset28  (n_p_reset28),
    .pwdata       (pwdata[6:0]),
    .clk_ctrl_sel (clk_ctrl_sel),
    .restart      (restart),
    .count_en     (count_en),
    .clk_ctrl     (clk_ctrl)
  );

  // ----------------------------------------
  // tick generation and counting
  // ----------------------------------------
  ttc_prescaler u_prescaler (
    .pclk28      (pclk28),
    .n_p_reset28 (n_p_reset28),
    .count_en    (count_en),
    .clk_ctrl    (clk_ctrl),
    .tick        (tick)
  );

  ttc_counter u_counter (
    .pclk28      (pclk28),
    .n_p_reset28 (n_p_reset28),
    .count_en    (count_en),
    .tick        (tick),
    .dis         (dis),
    .intv_mode   (intv_mode),
    .match_en    (match_en),
    .interval    (interval),
    .match       (match),
    .cnt_val     (cnt_val),
    .ovf_ev      (ovf_ev),
    .intv_ev     (intv_ev),
    .match_ev    (match_ev)
  );

endmodule

`default_nettype wire

/* verif/ttc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ttc_params.svh"

module ttc_tb;
  import ttc_pkg::*;

  localparam time CLK_PERIOD   = 4;
  localparam int  RESET_CYC    = 10;
  localparam int  SEED         = 80757;
  localparam int  IRQ_WAIT_CYC = 100;

  // rough cycle budget of each test
  localparam time LEN_RESET     = 30;
  localparam time LEN_READBACK  = 100;
  localparam time LEN_COUNT     = 120;
  localparam time LEN_PRESCALE  = 150;
  localparam time LEN_INTERVAL  = 130;
  localparam time LEN_MATCH     = 130;
  localparam time LEN_RESTART   = 110;
  localparam time LEN_TOTAL     = LEN_RESET + LEN_READBACK + LEN_COUNT + LEN_PRESCALE
                                  + LEN_INTERVAL + LEN_MATCH + LEN_RESTART;
  localparam time WATCHDOG_NS   = 20 * LEN_TOTAL * CLK_PERIOD;

  // counter control write values
  localparam logic [31:0] CTRL_DIS     = 32'h1 << `TTC_CTRL_DIS;
  localparam logic [31:0] CTRL_INTV    = 32'h1 << `TTC_CTRL_INTV;
  localparam logic [31:0] CTRL_MATCH   = 32'h1 << `TTC_CTRL_MATCH;
  localparam logic [31:0] CTRL_RESTART = 32'h1 << `TTC_CTRL_RESTART;

  logic        pclk28;
  logic        n_p_reset28;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        irq;

  int  err_cnt = 0;
  // edge of the last write, sample point of the last read
  time wr_time;
  time rd_time;

  ttc_timer u_ttc_timer (
    .pclk28      (pclk28),
    .n_p_reset28 (n_p_reset28),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq)
  );

  initial pclk28 = 1'b0;
  always #(CLK_PERIOD / 2) pclk28 = ~pclk28;

  // ----------------------------------------
  // error reporting
  // ----------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    err_cnt++;
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  // ----------------------------------------
  // APB master
  // ----------------------------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    // setup phase
    @(posedge pclk28);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk28);
    penable <= 1'b1;
    // write lands on this edge
    @(posedge pclk28);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    wr_time = $time;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge pclk28);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge pclk28);
    penable <= 1'b1;
    // prdata settled mid access
    @(negedge pclk28);
    data    = prdata;
    rd_time = $time;
    @(posedge pclk28);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_and_compare(input logic [7:0] addr, input string name,
                                  input logic [31:0] exp);
    logic [31:0] rdata;
    apb_read(addr, rdata);
    assert (rdata === exp)
    else report_mismatch(name, exp, rdata);
  endtask

  task automatic wait_for_irq();
    int n;
    n = 0;
    @(negedge pclk28);
    while (irq !== 1'b1 && n < IRQ_WAIT_CYC)
    begin
      @(negedge pclk28);
      n++;
    end
    assert (irq === 1'b1)
    else report_failure("irq did not rise within the wait limit");
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic check_reset_values();
    assert (irq === 1'b0)
    else report_mismatch("irq", 32'h0, {31'h0, irq});
    read_and_compare(`TTC_ADDR_CLK_CTRL, "clk_ctrl", 32'h0);
    read_and_compare(`TTC_ADDR_CNTR_CTRL, "cntr_ctrl", 32'h0);
    read_and_compare(`TTC_ADDR_INTERVAL, "interval", 32'h0);
    read_and_compare(`TTC_ADDR_MATCH, "match", 32'h0);
    read_and_compare(`TTC_ADDR_INT_STS, "int_sts", 32'h0);
  endtask

  // random values, masked to register width
  task automatic readback_registers();
    logic [31:0] data;
    for (int i = 0; i < 4; i++)
    begin
      data = $urandom;
      apb_write(`TTC_ADDR_CLK_CTRL, data);
      read_and_compare(`TTC_ADDR_CLK_CTRL, "clk_ctrl", data & 32'h7F);
      data = $urandom;
      apb_write(`TTC_ADDR_INTERVAL, data);
      read_and_compare(`TTC_ADDR_INTERVAL, "interval", data & 32'hFFFF);
      data = $urandom;
      apb_write(`TTC_ADDR_MATCH, data);
      read_and_compare(`TTC_ADDR_MATCH, "match", data & 32'hFFFF);
      // restart bit is write only
      data = $urandom;
      apb_write(`TTC_ADDR_CNTR_CTRL, data);
      read_and_compare(`TTC_ADDR_CNTR_CTRL, "cntr_ctrl", data & 32'hF);
    end
  endtask

  task automatic count_unprescaled();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] exp;
    time         t1;
    int          k;
    int          cyc;
    apb_write(`TTC_ADDR_CLK_CTRL, 32'h0);
    apb_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    k = 8 + int'($urandom % 40);
    apb_read(`TTC_ADDR_CNT_VAL, v1);
    t1 = rd_time;
    repeat (k) @(posedge pclk28);
    apb_read(`TTC_ADDR_CNT_VAL, v2);
    // one step per cycle, 16 bit wrap
    cyc = int'((rd_time - t1) / CLK_PERIOD);
    exp = (v1 + cyc) & 32'hFFFF;
    assert (v2 === exp)
    else report_mismatch("cnt_val", exp, v2);
    // dis holds the value
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_DIS);
    apb_read(`TTC_ADDR_CNT_VAL, v1);
    repeat (k) @(posedge pclk28);
    apb_read(`TTC_ADDR_CNT_VAL, v2);
    assert (v2 === v1)
    else report_mismatch("cnt_val frozen", v1, v2);
  endtask

  task automatic count_prescaled();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] diff;
    time         t1;
    int          n;
    int          period;
    int          k;
    int          cyc;
    n = int'($urandom % 4);
    period = 1 << (n + 1);
    apb_write(`TTC_ADDR_CLK_CTRL, (n << `TTC_CLK_PS_LSB) | (1 << `TTC_CLK_PS_EN));
    apb_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    k = 64 + int'($urandom % 64);
    apb_read(`TTC_ADDR_CNT_VAL, v1);
    t1 = rd_time;
    repeat (k) @(posedge pclk28);
    apb_read(`TTC_ADDR_CNT_VAL, v2);
    cyc = int'((rd_time - t1) / CLK_PERIOD);
    diff = (v2 - v1) & 32'hFFFF;
    // one tick per period, phase unknown
    assert (int'(diff) >= cyc / period - 1 && int'(diff) <= cyc / period + 1)
    else report_mismatch("cnt_val step", cyc / period, diff);
  endtask

  task automatic interval_interrupt();
    logic [31:0] intv;
    logic [31:0] rdata;
    intv = 32'd4 + ($urandom % 12);
    apb_write(`TTC_ADDR_CLK_CTRL, 32'h0);
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_DIS);
    apb_write(`TTC_ADDR_INTERVAL, intv);
    // drop stale events
    apb_read(`TTC_ADDR_INT_STS, rdata);
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_INTV | CTRL_RESTART);
    for (int i = 0; i < 10; i++)
    begin
      apb_read(`TTC_ADDR_CNT_VAL, rdata);
      assert (rdata <= intv)
      else report_mismatch("cnt_val limit", intv, rdata);
    end
    wait_for_irq();
    // freeze so no new event races the reads
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_DIS | CTRL_INTV);
    read_and_compare(`TTC_ADDR_INT_STS, "int_sts", 32'h1 << INT_INTV);
    @(negedge pclk28);
    assert (irq === 1'b0)
    else report_mismatch("irq", 32'h0, {31'h0, irq});
    read_and_compare(`TTC_ADDR_INT_STS, "int_sts", 32'h0);
  endtask

  task automatic match_interrupt();
    logic [31:0] intv;
    logic [31:0] m;
    logic [31:0] rdata;
    intv = 32'd8 + ($urandom % 8);
    m = 32'd1 + ($urandom % (intv - 32'd1));
    // frozen at zero, so the enabling cycle hits neither compare
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_DIS | CTRL_RESTART);
    apb_write(`TTC_ADDR_INTERVAL, intv);
    apb_write(`TTC_ADDR_MATCH, m);
    apb_read(`TTC_ADDR_INT_STS, rdata);
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_INTV | CTRL_MATCH | CTRL_RESTART);
    wait_for_irq();
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_DIS | CTRL_INTV | CTRL_MATCH);
    apb_read(`TTC_ADDR_INT_STS, rdata);
    assert (rdata[INT_MATCH] === 1'b1)
    else report_mismatch("int_sts match bit", 32'h1, {31'h0, rdata[INT_MATCH]});
  endtask

  task automatic restart_counter();
    logic [31:0] rdata;
    time         t_wr;
    int          cyc;
    apb_write(`TTC_ADDR_CLK_CTRL, 32'h0);
    apb_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    repeat (50) @(posedge pclk28);
    apb_read(`TTC_ADDR_CNT_VAL, rdata);
    assert (rdata >= 32'd40)
    else report_mismatch("cnt_val before restart", 32'd40, rdata);
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_RESTART);
    t_wr = wr_time;
    apb_read(`TTC_ADDR_CNT_VAL, rdata);
    cyc = int'((rd_time - t_wr) / CLK_PERIOD);
    assert (int'(rdata) <= cyc - 2)
    else report_mismatch("cnt_val after restart", cyc - 2, rdata);
    // cleared two edges after the write, then one step per cycle
    repeat (20) @(posedge pclk28);
    apb_read(`TTC_ADDR_CNT_VAL, rdata);
    cyc = int'((rd_time - t_wr) / CLK_PERIOD);
    assert (int'(rdata) == cyc - 2)
    else report_mismatch("cnt_val resumed", cyc - 2, rdata);
    // back to back restarts
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_RESTART);
    apb_write(`TTC_ADDR_CNTR_CTRL, CTRL_RESTART);
    t_wr = wr_time;
    apb_read(`TTC_ADDR_CNT_VAL, rdata);
    cyc = int'((rd_time - t_wr) / CLK_PERIOD);
    assert (int'(rdata) <= cyc - 2)
    else report_mismatch("cnt_val second restart", cyc - 2, rdata);
  endtask

  // ----------------------------------------
  // bus and reset checks
  // ----------------------------------------
  // all registers fit in the low half
  a_prdata_upper: assert property (
    @(posedge pclk28) disable iff (!n_p_reset28)
    (psel && penable && !pwrite) |-> (prdata[31:16] == 16'h0)
  ) else report_mismatch("prdata[31:16]", 32'h0, {16'h0, prdata[31:16]});

  a_irq_reset: assert property (
    @(posedge pclk28) !n_p_reset28 |-> !irq
  ) else report_mismatch("irq", 32'h0, {31'h0, irq});

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    void'($urandom(SEED));
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    n_p_reset28 = 1'b0;
    repeat (RESET_CYC) @(posedge pclk28);
    n_p_reset28 <= 1'b1;
    check_reset_values();
    readback_registers();
    count_unprescaled();
    count_prescaled();
    interval_interrupt();
    match_interrupt();
    restart_counter();
    repeat (4) @(posedge pclk28);
    $display("checks failed: %0d", err_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // watchdog, generous margin over the test budget
  initial
  begin
    #(WATCHDOG_NS);
    err_cnt++;
    $display("run timed out at %0t before the tests finished", $time);
    $display("checks failed: %0d", err_cnt);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/ttc_pkg.sv
hw/ttc_apb_regs.sv
hw/ttc_count_rst.sv
hw/ttc_prescaler.sv
hw/ttc_counter.sv
hw/ttc_timer.sv
verif/ttc_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0 --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps
TOP        = ttc_tb
FILELIST   = all.f
OBJ_DIR    = obj_dir
PASS_MSG   = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
